// ==== verilog/ctrl_pkg.sv ====
// controller package with states, selector encodings, cause codes and bundle structs
`default_nettype none

package ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // widths and cause codes
  ////////////////////////////////////////////////////////////

  localparam int CAUSE_W  = 6;
  localparam int IRQ_ID_W = 5;

  // machine exception codes as written to mcause
  localparam logic [CAUSE_W-1:0] EXC_ILLEGAL    = 6'd2;
  localparam logic [CAUSE_W-1:0] EXC_BREAKPOINT = 6'd3;
  localparam logic [CAUSE_W-1:0] EXC_ECALL_M    = 6'd11;

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  // main controller FSM states
  typedef enum logic [3:0] {
    RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE,
    IRQ_FLUSH, IRQ_TAKEN_ID, IRQ_TAKEN_IF, FLUSH_EX, FLUSH_WB
  } ctrl_state_e;

  // fetch pc source
  typedef enum logic [2:0] {
    PC_BOOT, PC_JUMP, PC_BRANCH, PC_EXCEPTION, PC_ERET
  } pc_sel_e;

  // exception vector offset
  typedef enum logic [1:0] {
    EXC_PC_IRQ, EXC_PC_ECALL, EXC_PC_ILLINSN
  } exc_pc_sel_e;

  // operand source for the ID stage muxes
  typedef enum logic [1:0] {
    SEL_REGFILE, SEL_FW_EX, SEL_FW_WB
  } fwd_sel_e;

  // jump class seen by the decoder
  typedef enum logic [1:0] {
    BRANCH_NONE, BRANCH_JAL, BRANCH_JALR, BRANCH_COND
  } jump_kind_e;

  ////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////

  // interrupt view of mcause: msb flags an interrupt
  typedef struct packed {
    logic                flag;
    logic [IRQ_ID_W-1:0] id;
  } irq_cause_t;

  // same 6 bits, read either as interrupt or as exception code
  typedef union packed {
    irq_cause_t         intr;
    logic [CAUSE_W-1:0] code;
  } cause_u;

  typedef struct packed {
    logic       illegal;
    logic       ecall;
    logic       mret;
    logic       ebrk;
    logic       csr_status;
    logic       pipe_flush;
    jump_kind_e jump_kind;
    logic       instr_valid;
  } decode_flags_t;

  // write enables, then rd-equals-rs match bits per producer
  typedef struct packed {
    logic we_ex;
    logic we_wb;
    logic alu_we_fw;
    logic ex_is_a;
    logic ex_is_b;
    logic ex_is_c;
    logic wb_is_a;
    logic wb_is_b;
    logic wb_is_c;
    logic alu_is_a;
    logic alu_is_b;
    logic alu_is_c;
  } hazard_in_t;

  typedef struct packed {
    fwd_sel_e a;
    fwd_sel_e b;
    fwd_sel_e c;
  } fwd_sel_t;

  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_sel;
    exc_pc_sel_e exc_pc_sel;
  } pc_ctrl_t;

  typedef struct packed {
    logic   save_if;
    logic   save_id;
    logic   save_cause;
    logic   restore_mret;
    cause_u cause;
  } csr_ctrl_t;

endpackage

`default_nettype wire

// ==== verilog/ctrl_fsm.sv ====
// main controller FSM with next-state, pc and csr action decoding and its registers
`timescale 1ns/1ns
`default_nettype none

module ctrl_fsm (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          fetch_enable_i,
  input  logic                          id_ready_i,
  input  logic                          ex_valid_i,
  input  logic                          branch_taken_ex_i,
  input  logic                          jr_stall_i,
  input  logic                          irq_req_i,
  input  logic [ctrl_pkg::IRQ_ID_W-1:0] irq_id_i,
  input  logic                          m_ie_i,
  input  ctrl_pkg::decode_flags_t       dec_i,
  output logic                          ctrl_busy_o,
  output logic                          first_fetch_o,
  output logic                          is_decoding_o,
  output logic                          instr_req_o,
  output logic                          halt_if_o,
  output logic                          halt_id_o,
  output logic                          exc_kill_o,
  output logic                          irq_ack_o,
  output logic                          exc_ack_o,
  output ctrl_pkg::pc_ctrl_t            pc_ctrl_o,
  output ctrl_pkg::csr_ctrl_t           csr_ctrl_o
);

  import ctrl_pkg::*;

  ctrl_state_e ctrl_fsm_cs;
  ctrl_state_e ctrl_fsm_ns;

  logic jump_done;
  logic jump_done_q;
  logic boot_done;
  logic boot_done_q;
  logic irq_enable;
  logic jump_in_dec;
  logic trap_in_dec;

  // machine mode only, so mie alone gates interrupts
  assign irq_enable  = irq_req_i & m_ie_i;
  // jal and jalr are resolved in ID, conditional branches in EX
  assign jump_in_dec = (dec_i.jump_kind == BRANCH_JAL) || (dec_i.jump_kind == BRANCH_JALR);
  // everything that needs an empty pipe before it acts
  assign trap_in_dec = dec_i.illegal | dec_i.ecall | dec_i.mret | dec_i.ebrk | dec_i.pipe_flush;

  ////////////////////////////////////////////////////////////
  // next state and output decode
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    ctrl_fsm_ns   = ctrl_fsm_cs;
    jump_done     = jump_done_q;
    boot_done     = 1'b0;

    ctrl_busy_o   = 1'b1;
    first_fetch_o = 1'b0;
    is_decoding_o = 1'b0;
    instr_req_o   = 1'b1;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    exc_kill_o    = 1'b0;
    irq_ack_o     = 1'b0;
    exc_ack_o     = 1'b0;

    pc_ctrl_o            = '0;
    pc_ctrl_o.pc_sel     = PC_BOOT;
    pc_ctrl_o.exc_pc_sel = EXC_PC_IRQ;
    csr_ctrl_o           = '0;

    case (ctrl_fsm_cs)
      // idle until fetch is enabled
      RESET:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i)
          ctrl_fsm_ns = BOOT_SET;
      end

      // load boot address into the prefetcher
      BOOT_SET:
      begin
        pc_ctrl_o.pc_set = 1'b1;
        pc_ctrl_o.pc_sel = PC_BOOT;
        boot_done        = 1'b1;
        ctrl_fsm_ns      = FIRST_FETCH;
      end

      // one cycle of drain before sleeping
      WAIT_SLEEP:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        ctrl_fsm_ns = SLEEP;
      end

      SLEEP:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        // wake on fetch enable or any pending request, even if masked
        if (fetch_enable_i || irq_req_i)
          ctrl_fsm_ns = boot_done_q ? FIRST_FETCH : BOOT_SET;
      end

      FIRST_FETCH:
      begin
        first_fetch_o = 1'b1;
        // wait out the IF miss
        if (id_ready_i)
          ctrl_fsm_ns = DECODE;
        // pipe is empty here, so the interrupt saves the IF pc
        if (irq_enable)
        begin
          halt_if_o   = 1'b1;
          halt_id_o   = 1'b1;
          ctrl_fsm_ns = IRQ_TAKEN_IF;
        end
      end

      DECODE:
      begin
        if (branch_taken_ex_i)
        begin
          // taken branch in EX wins over whatever sits in ID
          pc_ctrl_o.pc_set = 1'b1;
          pc_ctrl_o.pc_sel = PC_BRANCH;
        end
        else if (dec_i.instr_valid)
        begin
          is_decoding_o = 1'b1;
          if (irq_enable)
          begin
            halt_if_o   = 1'b1;
            halt_id_o   = 1'b1;
            ctrl_fsm_ns = IRQ_FLUSH;
          end
          else
          begin
            // request pending but masked
            exc_kill_o = irq_req_i;
            if (jump_in_dec)
            begin
              pc_ctrl_o.pc_sel = PC_JUMP;
              // set the pc once, and only after the jr stall is gone
              if (!jr_stall_i && !jump_done_q)
              begin
                pc_ctrl_o.pc_set = 1'b1;
                jump_done        = 1'b1;
              end
            end
            else if (trap_in_dec)
            begin
              halt_if_o   = 1'b1;
              halt_id_o   = 1'b1;
              ctrl_fsm_ns = FLUSH_EX;
            end
            else if (dec_i.csr_status)
            begin
              halt_if_o   = 1'b1;
              ctrl_fsm_ns = id_ready_i ? FLUSH_EX : DECODE;
            end
          end
        end
      end

      // hold until EX has retired its instruction
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
          ctrl_fsm_ns = FLUSH_WB;
      end

      // recheck, mie may have been cleared by the instruction in EX
      IRQ_FLUSH:
      begin
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        ctrl_fsm_ns = irq_enable ? IRQ_TAKEN_ID : DECODE;
      end

      // take the interrupt, saving the ID or the IF pc
      IRQ_TAKEN_ID, IRQ_TAKEN_IF:
      begin
        pc_ctrl_o.pc_set         = 1'b1;
        pc_ctrl_o.pc_sel         = PC_EXCEPTION;
        pc_ctrl_o.exc_pc_sel     = EXC_PC_IRQ;
        csr_ctrl_o.save_id       = (ctrl_fsm_cs == IRQ_TAKEN_ID);
        csr_ctrl_o.save_if       = (ctrl_fsm_cs == IRQ_TAKEN_IF);
        csr_ctrl_o.save_cause    = 1'b1;
        csr_ctrl_o.cause.intr.flag = 1'b1;
        csr_ctrl_o.cause.intr.id   = irq_id_i;
        irq_ack_o                = 1'b1;
        exc_ack_o                = 1'b1;
        ctrl_fsm_ns              = DECODE;
      end

      // pipe is empty, the instruction still in ID decides the action
      FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (dec_i.ecall)
        begin
          pc_ctrl_o.pc_set      = 1'b1;
          pc_ctrl_o.pc_sel      = PC_EXCEPTION;
          pc_ctrl_o.exc_pc_sel  = EXC_PC_ECALL;
          csr_ctrl_o.save_id    = 1'b1;
          csr_ctrl_o.save_cause = 1'b1;
          csr_ctrl_o.cause.code = EXC_ECALL_M;
        end
        else if (dec_i.illegal)
        begin
          pc_ctrl_o.pc_set      = 1'b1;
          pc_ctrl_o.pc_sel      = PC_EXCEPTION;
          pc_ctrl_o.exc_pc_sel  = EXC_PC_ILLINSN;
          csr_ctrl_o.save_id    = 1'b1;
          csr_ctrl_o.save_cause = 1'b1;
          csr_ctrl_o.cause.code = EXC_ILLEGAL;
        end
        else if (dec_i.mret)
        begin
          pc_ctrl_o.pc_set        = 1'b1;
          pc_ctrl_o.pc_sel        = PC_ERET;
          csr_ctrl_o.restore_mret = 1'b1;
        end
        else if (dec_i.ebrk)
        begin
          // breakpoint code is shown but not saved
          csr_ctrl_o.cause.code = EXC_BREAKPOINT;
        end
        ctrl_fsm_ns = fetch_enable_i ? DECODE : WAIT_SLEEP;
      end

      // unused encodings fall back to reset
      default:
      begin
        instr_req_o = 1'b0;
        ctrl_fsm_ns = RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // state registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ctrl_fsm_cs <= RESET;
      jump_done_q <= 1'b0;
      boot_done_q <= 1'b0;
    end
    else
    begin
      ctrl_fsm_cs <= ctrl_fsm_ns;
      boot_done_q <= boot_done | boot_done_q;
      // cleared once the jump leaves ID
      jump_done_q <= jump_done & ~id_ready_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/hazard_unit.sv ====
// hazard unit with load-use and jump-register stalls and the register write kill
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
  input  ctrl_pkg::jump_kind_e jump_kind_i,
  input  logic                 illegal_i,
  input  logic                 is_decoding_i,
  input  logic                 data_req_ex_i,
  input  logic                 wb_ready_i,
  input  ctrl_pkg::hazard_in_t haz_i,
  output logic                 load_stall_o,
  output logic                 jr_stall_o,
  output logic                 deassert_we_o
);

  import ctrl_pkg::*;

  logic load_pending;
  logic ex_hits_src;
  logic a_pending;

  // load in EX, or a WB that has not yet returned its data
  assign load_pending = (data_req_ex_i & haz_i.we_ex) | (~wb_ready_i & haz_i.we_wb);
  assign ex_hits_src  = haz_i.ex_is_a | haz_i.ex_is_b | haz_i.ex_is_c;

  // any producer still writing rs1, jalr needs it for the target
  assign a_pending = (haz_i.we_wb & haz_i.wb_is_a) |
                     (haz_i.we_ex & haz_i.ex_is_a) |
                     (haz_i.alu_we_fw & haz_i.alu_is_a);

  assign load_stall_o = load_pending & ex_hits_src;
  assign jr_stall_o   = (jump_kind_i == BRANCH_JALR) & a_pending;

  // no write from ID when idle, illegal or stalled
  assign deassert_we_o = ~is_decoding_i | illegal_i | load_stall_o | jr_stall_o;

endmodule

`default_nettype wire

// ==== verilog/fwd_unit.sv ====
// forwarding unit choosing the sources of operands a, b and c
`timescale 1ns/1ns
`default_nettype none

module fwd_unit (
  input  ctrl_pkg::hazard_in_t haz_i,
  input  logic                 data_misaligned_i,
  input  logic                 mult_multicycle_i,
  output ctrl_pkg::fwd_sel_t   fwd_o
);

  import ctrl_pkg::*;

  // EX result is younger than WB, so it wins
  function automatic fwd_sel_e pick_src(input logic wb_hit, input logic ex_hit);
    fwd_sel_e sel;
    sel = SEL_REGFILE;
    if (wb_hit)
      sel = SEL_FW_WB;
    if (ex_hit)
      sel = SEL_FW_EX;
    return sel;
  endfunction

  always_comb
  begin
    fwd_o.a = pick_src(haz_i.we_wb & haz_i.wb_is_a, haz_i.alu_we_fw & haz_i.alu_is_a);
    fwd_o.b = pick_src(haz_i.we_wb & haz_i.wb_is_b, haz_i.alu_we_fw & haz_i.alu_is_b);
    fwd_o.c = pick_src(haz_i.we_wb & haz_i.wb_is_c, haz_i.alu_we_fw & haz_i.alu_is_c);

    if (data_misaligned_i)
    begin
      // second half of a misaligned access reuses the EX address
      fwd_o.a = SEL_FW_EX;
      fwd_o.b = SEL_REGFILE;
    end
    else if (mult_multicycle_i)
    begin
      // multiplier keeps its partial result on operand c
      fwd_o.c = SEL_FW_EX;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/core_ctrl.sv ====
// controller top level joining the FSM, hazard unit and forwarding unit
`timescale 1ns/1ns
`default_nettype none

module core_ctrl (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          fetch_enable_i,
  input  logic                          id_ready_i,
  input  logic                          ex_valid_i,
  input  logic                          wb_ready_i,
  input  logic                          data_req_ex_i,
  input  logic                          data_misaligned_i,
  input  logic                          mult_multicycle_i,
  input  logic                          branch_taken_ex_i,
  input  logic                          irq_req_i,
  input  logic [ctrl_pkg::IRQ_ID_W-1:0] irq_id_i,
  input  logic                          m_ie_i,
  input  ctrl_pkg::decode_flags_t       dec_i,
  input  ctrl_pkg::hazard_in_t          haz_i,
  output logic                          ctrl_busy_o,
  output logic                          first_fetch_o,
  output logic                          is_decoding_o,
  output logic                          instr_req_o,
  output logic                          halt_if_o,
  output logic                          halt_id_o,
  output logic                          exc_kill_o,
  output logic                          irq_ack_o,
  output logic                          exc_ack_o,
  output ctrl_pkg::pc_ctrl_t            pc_ctrl_o,
  output ctrl_pkg::csr_ctrl_t           csr_ctrl_o,
  output logic                          load_stall_o,
  output logic                          jr_stall_o,
  output logic                          deassert_we_o,
  output ctrl_pkg::fwd_sel_t            fwd_o
);

  // FSM, jr_stall_o feeds back to hold the jump pc_set
  ctrl_fsm u_ctrl_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .jr_stall_i        (jr_stall_o),
    .irq_req_i         (irq_req_i),
    .irq_id_i          (irq_id_i),
    .m_ie_i            (m_ie_i),
    .dec_i             (dec_i),
    .ctrl_busy_o       (ctrl_busy_o),
    .first_fetch_o     (first_fetch_o),
    .is_decoding_o     (is_decoding_o),
    .instr_req_o       (instr_req_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o),
    .exc_kill_o        (exc_kill_o),
    .irq_ack_o         (irq_ack_o),
    .exc_ack_o         (exc_ack_o),
    .pc_ctrl_o         (pc_ctrl_o),
    .csr_ctrl_o        (csr_ctrl_o)
  );

  // stalls, gated by the decoding level from the FSM
  hazard_unit u_hazard_unit (
    .jump_kind_i   (dec_i.jump_kind),
    .illegal_i     (dec_i.illegal),
    .is_decoding_i (is_decoding_o),
    .data_req_ex_i (data_req_ex_i),
    .wb_ready_i    (wb_ready_i),
    .haz_i         (haz_i),
    .load_stall_o  (load_stall_o),
    .jr_stall_o    (jr_stall_o),
    .deassert_we_o (deassert_we_o)
  );

  fwd_unit u_fwd_unit (
    .haz_i             (haz_i),
    .data_misaligned_i (data_misaligned_i),
    .mult_multicycle_i (mult_multicycle_i),
    .fwd_o             (fwd_o)
  );

endmodule

`default_nettype wire

// ==== testbench/ctrl_props.sv ====
// concurrent assertions on the controller FSM, bound into ctrl_fsm
`timescale 1ns/1ns
`default_nettype none

module ctrl_props (
  input logic                 clk,
  input logic                 rst_n,
  input ctrl_pkg::ctrl_state_e state_i,
  input logic                 irq_req_i,
  input logic                 irq_ack_i,
  input logic                 pc_set_i,
  input logic                 branch_taken_i
);

  import ctrl_pkg::*;

  // an acknowledged interrupt redirects fetch while its request is still held
  irq_ack_sets_pc: assert property (@(posedge clk) disable iff (!rst_n)
    irq_ack_i |-> pc_set_i && irq_req_i)
    else $error("irq_ack without pc_set or without a pending request");

  no_pc_set_in_reset: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == RESET) |-> !pc_set_i)
    else $error("pc_set while in RESET");

  // the branch shadow kills the next EX slot
  no_back_to_back_branch: assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken_i |=> !branch_taken_i)
    else $error("taken branch on two consecutive cycles");

endmodule

bind ctrl_fsm ctrl_props u_props (
  .clk            (clk),
  .rst_n          (rst_n),
  .state_i        (ctrl_fsm_cs),
  .irq_req_i      (irq_req_i),
  .irq_ack_i      (irq_ack_o),
  .pc_set_i       (pc_ctrl_o.pc_set),
  .branch_taken_i (branch_taken_ex_i)
);

`default_nettype wire

// ==== testbench/ctrl_checker.sv ====
// output checker comparing DUT responses with golden expectations per cycle
`timescale 1ns/1ns
`default_nettype none

module ctrl_checker (
  input  logic       clk,
  input  logic       active_i,
  input  logic       end_i,
  input  int         test_i,
  input  logic [8:0] exp_status_i,
  input  logic [5:0] exp_pc_i,
  input  logic [9:0] exp_csr_i,
  input  logic [2:0] exp_stall_i,
  input  logic [5:0] exp_fwd_i,
  input  logic [8:0] act_status_i,
  input  logic [5:0] act_pc_i,
  input  logic [9:0] act_csr_i,
  input  logic [2:0] act_stall_i,
  input  logic [5:0] act_fwd_i,
  output int         err_cnt_o,
  output int         test_cnt_o,
  output int         fail_cnt_o
);

  int   cur_test;
  int   test_errs;
  logic have_test;

  initial
  begin
    err_cnt_o  = 0;
    test_cnt_o = 0;
    fail_cnt_o = 0;
    cur_test   = 0;
    test_errs  = 0;
    have_test  = 1'b0;
  end

  task automatic compare_field(input string name, input logic [11:0] exp_v,
                               input logic [11:0] act_v);
    if (exp_v !== act_v)
    begin
      $display("ERROR test %0d %s expected %h got %h", cur_test, name, exp_v, act_v);
      err_cnt_o = err_cnt_o + 1;
      test_errs = test_errs + 1;
    end
  endtask

  task automatic close_test();
    test_cnt_o = test_cnt_o + 1;
    if (test_errs != 0)
      fail_cnt_o = fail_cnt_o + 1;
    $display("test %0d done with %0d mismatches", cur_test, test_errs);
  endtask

  // outputs are settled by the falling edge
  always @(negedge clk)
  begin
    if (active_i)
    begin
      if (!have_test || test_i != cur_test)
      begin
        if (have_test)
          close_test();
        cur_test  = test_i;
        test_errs = 0;
        have_test = 1'b1;
      end
      compare_field("status", {3'b0, exp_status_i}, {3'b0, act_status_i});
      compare_field("pc_ctrl", {6'b0, exp_pc_i}, {6'b0, act_pc_i});
      compare_field("csr_ctrl", {2'b0, exp_csr_i}, {2'b0, act_csr_i});
      compare_field("stalls", {9'b0, exp_stall_i}, {9'b0, act_stall_i});
      compare_field("fwd", {6'b0, exp_fwd_i}, {6'b0, act_fwd_i});
    end
    else if (end_i && have_test)
    begin
      close_test();
      have_test = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_core_ctrl.sv ====
// testbench top with clock, reset, golden vector stimulus, timeout and run summary
`timescale 1ns/1ns
`default_nettype none

module tb_core_ctrl;

  import ctrl_pkg::*;

  localparam int MAX_VEC    = 64;
  localparam int RST_CYCLES = 10;

  logic clk;
  logic rst_n;

  // DUT inputs
  logic                fetch_enable;
  logic                id_ready;
  logic                ex_valid;
  logic                wb_ready;
  logic                data_req_ex;
  logic                data_misaligned;
  logic                mult_multicycle;
  logic                branch_taken_ex;
  logic                irq_req;
  logic [IRQ_ID_W-1:0] irq_id;
  logic                m_ie;
  decode_flags_t       dec;
  hazard_in_t          haz;

  // DUT outputs
  logic       ctrl_busy;
  logic       first_fetch;
  logic       is_decoding;
  logic       instr_req;
  logic       halt_if;
  logic       halt_id;
  logic       exc_kill;
  logic       irq_ack;
  logic       exc_ack;
  pc_ctrl_t   pc_ctrl;
  csr_ctrl_t  csr_ctrl;
  logic       load_stall;
  logic       jr_stall;
  logic       deassert_we;
  fwd_sel_t   fwd;

  // golden vectors, one entry per cycle
  int         v_test   [MAX_VEC];
  logic [9:0] v_ctl    [MAX_VEC];
  logic [8:0] v_dec    [MAX_VEC];
  logic [11:0] v_haz   [MAX_VEC];
  logic [4:0] v_irq_id [MAX_VEC];
  logic [8:0] v_status [MAX_VEC];
  logic [5:0] v_pc     [MAX_VEC];
  logic [9:0] v_csr    [MAX_VEC];
  logic [2:0] v_stall  [MAX_VEC];
  logic [5:0] v_fwd    [MAX_VEC];
  int         n_vec;

  // expected values and control handed to the checker
  int         exp_test;
  logic [8:0] exp_status;
  logic [5:0] exp_pc;
  logic [9:0] exp_csr;
  logic [2:0] exp_stall;
  logic [5:0] exp_fwd;
  logic       chk_active;
  logic       chk_end;
  int         err_cnt;
  int         test_cnt;
  int         fail_cnt;

  int         cycles;
  int         cycle_limit;

  always #2 clk = ~clk;

  core_ctrl u_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable),
    .id_ready_i        (id_ready),
    .ex_valid_i        (ex_valid),
    .wb_ready_i        (wb_ready),
    .data_req_ex_i     (data_req_ex),
    .data_misaligned_i (data_misaligned),
    .mult_multicycle_i (mult_multicycle),
    .branch_taken_ex_i (branch_taken_ex),
    .irq_req_i         (irq_req),
    .irq_id_i          (irq_id),
    .m_ie_i            (m_ie),
    .dec_i             (dec),
    .haz_i             (haz),
    .ctrl_busy_o       (ctrl_busy),
    .first_fetch_o     (first_fetch),
    .is_decoding_o     (is_decoding),
    .instr_req_o       (instr_req),
    .halt_if_o         (halt_if),
    .halt_id_o         (halt_id),
    .exc_kill_o        (exc_kill),
    .irq_ack_o         (irq_ack),
    .exc_ack_o         (exc_ack),
    .pc_ctrl_o         (pc_ctrl),
    .csr_ctrl_o        (csr_ctrl),
    .load_stall_o      (load_stall),
    .jr_stall_o        (jr_stall),
    .deassert_we_o     (deassert_we),
    .fwd_o             (fwd)
  );

  ctrl_checker u_checker (
    .clk          (clk),
    .active_i     (chk_active),
    .end_i        (chk_end),
    .test_i       (exp_test),
    .exp_status_i (exp_status),
    .exp_pc_i     (exp_pc),
    .exp_csr_i    (exp_csr),
    .exp_stall_i  (exp_stall),
    .exp_fwd_i    (exp_fwd),
    .act_status_i ({ctrl_busy, first_fetch, is_decoding, instr_req, halt_if,
                    halt_id, exc_kill, irq_ack, exc_ack}),
    .act_pc_i     (pc_ctrl),
    .act_csr_i    (csr_ctrl),
    .act_stall_i  ({load_stall, jr_stall, deassert_we}),
    .act_fwd_i    (fwd),
    .err_cnt_o    (err_cnt),
    .test_cnt_o   (test_cnt),
    .fail_cnt_o   (fail_cnt)
  );

  // skips comment lines, keeps lines with all ten columns
  task automatic load_vectors();
    int    fd;
    int    got;
    string line;
    n_vec = 0;
    fd = $fopen("testbench/ctrl_golden.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the golden vector file");
      return;
    end
    while (!$feof(fd) && n_vec < MAX_VEC)
    begin
      line = "";
      got = $fgets(line, fd);
      if (got > 1 && line[0] != "#")
      begin
        got = $sscanf(line, "%d %b %h %h %h %b %h %h %b %h",
                      v_test[n_vec], v_ctl[n_vec], v_dec[n_vec], v_haz[n_vec],
                      v_irq_id[n_vec], v_status[n_vec], v_pc[n_vec], v_csr[n_vec],
                      v_stall[n_vec], v_fwd[n_vec]);
        if (got == 10)
          n_vec = n_vec + 1;
      end
    end
    $fclose(fd);
  endtask

  // run limit: two cycles per vector plus reset
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Test failures found");
      $finish;
    end
  end

  initial
  begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    fetch_enable    = 1'b0;
    id_ready        = 1'b0;
    ex_valid        = 1'b0;
    wb_ready        = 1'b0;
    data_req_ex     = 1'b0;
    data_misaligned = 1'b0;
    mult_multicycle = 1'b0;
    branch_taken_ex = 1'b0;
    irq_req         = 1'b0;
    irq_id          = '0;
    m_ie            = 1'b0;
    dec             = '0;
    haz             = '0;
    exp_test        = 0;
    exp_status      = '0;
    exp_pc          = '0;
    exp_csr         = '0;
    exp_stall       = '0;
    exp_fwd         = '0;
    chk_active      = 1'b0;
    chk_end         = 1'b0;
    cycles          = 0;
    cycle_limit     = 2 * MAX_VEC + RST_CYCLES;

    load_vectors();
    cycle_limit = 2 * n_vec + RST_CYCLES;

    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < n_vec; i++)
    begin
      @(posedge clk);
      {fetch_enable, id_ready, ex_valid, wb_ready, data_req_ex, data_misaligned,
       mult_multicycle, branch_taken_ex, irq_req, m_ie} <= v_ctl[i];
      dec        <= decode_flags_t'(v_dec[i]);
      haz        <= hazard_in_t'(v_haz[i]);
      irq_id     <= v_irq_id[i];
      exp_test   <= v_test[i];
      exp_status <= v_status[i];
      exp_pc     <= v_pc[i];
      exp_csr    <= v_csr[i];
      exp_stall  <= v_stall[i];
      exp_fwd    <= v_fwd[i];
      chk_active <= 1'b1;
    end

    // let the checker close the last test
    @(posedge clk);
    chk_active <= 1'b0;
    chk_end    <= 1'b1;
    @(posedge clk);
    @(posedge clk);

    $display("tests run %0d, tests failed %0d, mismatches %0d, vectors %0d",
             test_cnt, fail_cnt, err_cnt, n_vec);
    if (err_cnt == 0 && n_vec > 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/ctrl_golden.txt ====
# test ctl(fe idr exv wbr dreq mis mult br irq mie) dec haz irq_id | expected:
# status(busy ff dec req hif hid kill ack eack) pc_ctrl csr_ctrl stalls(load jr dwe) fwd
1 1001000000 000 000 00 000000000 00 000 001 00
1 1001000000 000 000 00 100100000 20 000 001 00
1 1001000000 000 000 00 110100000 00 000 001 00
1 1101000000 000 000 00 110100000 00 000 001 00
1 1101000000 000 000 00 100100000 00 000 001 00
2 1101000000 000 420 00 100100000 00 000 001 20
2 1101000000 000 634 00 100100000 00 000 001 18
2 1101000000 000 209 00 100100000 00 000 001 01
2 1101010000 000 634 00 100100000 00 000 001 10
2 1101001000 000 420 00 100100000 00 000 001 21
2 1101011000 000 420 00 100100000 00 000 001 10
3 1101100000 001 880 00 101100000 00 000 101 00
3 1101000000 001 880 00 101100000 00 000 000 00
3 1001000000 005 900 00 101100000 04 000 011 00
3 1001000000 005 000 00 101100000 24 000 000 00
3 1001000000 005 000 00 101100000 04 000 000 00
3 1101000000 005 000 00 101100000 04 000 000 00
3 1101000000 000 000 00 100100000 00 000 001 00
4 1101000000 101 000 00 101111000 00 000 001 00
4 1101000000 101 000 00 100111000 00 000 001 00
4 1111000000 101 000 00 100111000 00 000 001 00
4 1111000000 101 000 00 100111000 2e 182 001 00
4 1101000000 000 000 00 100100000 00 000 001 00
4 1111000000 081 000 00 101111000 00 000 000 00
4 1111000000 081 000 00 100111000 00 000 001 00
4 1111000000 081 000 00 100111000 2d 18b 001 00
4 1101000000 000 000 00 100100000 00 000 001 00
5 1101000011 001 000 07 101111000 00 000 000 00
5 1101000011 001 000 07 100111000 00 000 001 00
5 1101000011 001 000 07 100100011 2c 1a7 001 00
5 1101000000 001 000 00 101100000 00 000 000 00
5 1101000010 001 000 00 101100100 00 000 000 00
5 1101000000 000 000 00 100100000 00 000 001 00
6 0101000000 041 000 00 101111000 00 000 000 00
6 0111000000 041 000 00 100111000 00 000 001 00
6 0101000000 041 000 00 100111000 30 040 001 00
6 0001000000 000 000 00 000011000 00 000 001 00
6 0001000000 000 000 00 000011000 00 000 001 00
6 0001000010 000 000 00 000011000 00 000 001 00
6 1001000000 000 000 00 110100000 00 000 001 00
6 1101000000 000 000 00 110100000 00 000 001 00
6 1101000000 000 000 00 100100000 00 000 001 00

// ==== vlog.f ====
verilog/ctrl_pkg.sv
verilog/ctrl_fsm.sv
verilog/hazard_unit.sv
verilog/fwd_unit.sv
verilog/core_ctrl.sv
testbench/ctrl_props.sv
testbench/ctrl_checker.sv
testbench/tb_core_ctrl.sv

// ==== Makefile ====
# Verilator flow for the core controller
VERILATOR ?= verilator
TOP       ?= tb_core_ctrl
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= All tests passed!

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
